// File: checksumCore.sv
/*
 * Memory client in place of the core: streams reads of the loaded image, matches
 * responses by serial, sums rotated words, then stores and sends the checksum.
 */
`default_nettype none

module checksumCore (
    input  logic clk,
    input  logic rst,
    input  logic busy,
    input  mainTypes::MemSerial nextReadSerial,
    input  mainTypes::MemResponse resp,
    output mainTypes::MemRequest req,
    input  mainTypes::MemAddr wordCount,
    output logic serialWE,
    output logic [7:0] serialWriteData,
    input  logic serialReady,
    output logic [mainTypes::LED_WIDTH-1:0] ledOut,
    output logic done
);

    mainTypes::MemAddr issueCount;                  // Reads accepted so far
    mainTypes::MemAddr respCount;                   // Read data received so far
    logic [$clog2(mainTypes::MAX_IN_FLIGHT+1)-1:0] outstanding;
    mainTypes::MemAddr addrTable [1 << mainTypes::SERIAL_WIDTH];
    mainTypes::MemAddr respAddr;
    mainTypes::MemWord checksum;
    mainTypes::MemAddr lastAddr;                    // Shown on the LEDs
    logic writeIssued;
    logic writeAcked;
    logic [2:0] sendLane;                           // 4 once all bytes are out
    logic readAccept;
    logic writeAccept;
    logic byteSent;

    function automatic logic [31:0] rotateLeft(input logic [31:0] value,
                                               input logic [4:0] amount);
        logic [63:0] doubled;
        doubled = {value, value} << amount;
        return doubled[63:32];
    endfunction

    always_comb begin
        req.addr = issueCount;
        req.wdata = checksum;
        req.re = (issueCount != wordCount) && (outstanding < mainTypes::MAX_IN_FLIGHT);
        req.we = 1'b0;
        // All reads are back by now, so re is already low
        if (respCount == wordCount && !writeIssued) begin
            req.addr = wordCount;
            req.we = 1'b1;
        end
    end

    assign readAccept = req.re && !busy;
    assign writeAccept = req.we && !busy;
    assign byteSent = serialWE && serialReady;
    assign respAddr = addrTable[resp.readSerial];

    // Remember which address each read id belongs to
    always_ff @(posedge clk) begin
        if (readAccept) begin
            addrTable[nextReadSerial] <= issueCount;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            issueCount <= '0;
            respCount <= '0;
            outstanding <= '0;
            checksum <= '0;
            lastAddr <= '0;
            writeIssued <= 1'b0;
            writeAcked <= 1'b0;
            sendLane <= '0;
        end else begin
            if (readAccept) begin
                issueCount <= issueCount + 1'b1;
            end
            outstanding <= outstanding + readAccept - resp.readValid;

            if (resp.readValid) begin
                respCount <= respCount + 1'b1;
                checksum.word <= checksum.word + rotateLeft(resp.readData.word, respAddr[4:0]);
                lastAddr <= respAddr;
            end

            if (writeAccept) begin
                writeIssued <= 1'b1;
            end
            if (resp.writeDone && writeIssued) begin
                writeAcked <= 1'b1;
            end

            if (byteSent) begin
                sendLane <= sendLane + 1'b1;
            end
        end
    end

    // Byte held steady until serialReady takes it
    assign serialWE = writeAcked && !sendLane[2];
    assign serialWriteData = checksum.bytes[sendLane[1:0]];
    assign done = sendLane[2];

    assign ledOut = lastAddr[mainTypes::LED_WIDTH-1:0];

endmodule

`default_nettype wire

// File: list.f
mainTypes.sv
resetController.sv
memory.sv
programLoader.sv
checksumCore.sv
mainTop.sv
tbClock.sv
tbMain.sv

// File: mainTop.sv
/*
 * SoC top level with reset stretching, memory, program loader and checksum client.
 * The memory port belongs to the loader until loaded rises, then to the client.
 */
`default_nettype none

module mainTop (
    input  logic clk,
    input  logic rstN,
    input  logic [7:0] byteData,
    input  logic byteValid,
    input  logic serialReady,
    output logic sysRstOut,
    output logic serialWE,
    output logic [7:0] serialWriteData,
    output logic [mainTypes::LED_WIDTH-1:0] ledOut,
    output logic done
);

    logic sysRst;
    logic loaded;
    logic busy;
    mainTypes::MemAddr wordCount;
    mainTypes::MemSerial nextReadSerial;
    mainTypes::MemResponse resp;
    mainTypes::MemRequest loaderReq;
    mainTypes::MemRequest coreReq;
    mainTypes::MemRequest memReq;

    resetController rstCtrl (
        .clk(clk),
        .rstN(rstN),
        .sysRst(sysRst),
        .rstStart()
    );

    assign sysRstOut = sysRst;

    memory memUnit (
        .clk(clk),
        .rst(sysRst),
        .req(memReq),
        .busy(busy),
        .nextReadSerial(nextReadSerial),
        .nextWriteSerial(),
        .resp(resp)
    );

    always_comb begin
        if (!loaded) begin
            memReq = loaderReq;
        end else begin
            memReq = coreReq;
        end
    end

    programLoader loader (
        .clk(clk),
        .rst(sysRst),
        .byteData(byteData),
        .byteValid(byteValid),
        .busy(busy),
        .writeDone(resp.writeDone),
        .req(loaderReq),
        .wordCount(wordCount),
        .loaded(loaded)
    );

    // Held in reset until the image is in memory
    checksumCore core (
        .clk(clk),
        .rst(sysRst || !loaded),
        .busy(busy),
        .nextReadSerial(nextReadSerial),
        .resp(resp),
        .req(coreReq),
        .wordCount(wordCount),
        .serialWE(serialWE),
        .serialWriteData(serialWriteData),
        .serialReady(serialReady),
        .ledOut(ledOut),
        .done(done)
    );

endmodule

`default_nettype wire

// File: mainTypes.sv
/*
 * Shared sizes, memory word types and request/response structs for the SoC top.
 * Every design file refers to these through mainTypes:: scoped names.
 */
`default_nettype none

package mainTypes;

    // Memory geometry
    localparam int ADDR_WIDTH = 10;                     // Word address bits
    localparam int MEM_ENTRY_NUM = 1 << ADDR_WIDTH;     // 1024 words
    localparam int MEM_READ_LATENCY = 2;                // Accept to data, in cycles

    // Access serial numbers
    localparam int SERIAL_WIDTH = 3;                    // Eight ids
    localparam int MAX_IN_FLIGHT = 4;                   // Core read window

    // System level
    localparam int RESET_HOLD = 8;                      // Cycles sysRst outlasts rstN
    localparam int LED_WIDTH = 8;

    typedef logic [ADDR_WIDTH-1:0] MemAddr;
    typedef logic [SERIAL_WIDTH-1:0] MemSerial;

    // One memory word, seen either as a number or as four byte lanes
    typedef union packed {
        logic [31:0] word;                              // Checksum arithmetic
        logic [3:0][7:0] bytes;                         // Lane 0 is least significant
    } MemWord;

    // Client to memory
    typedef struct packed {
        MemAddr addr;
        MemWord wdata;
        logic re;
        logic we;
    } MemRequest;

    // Memory to client, both strobes carry the serial taken at acceptance
    typedef struct packed {
        logic readValid;
        MemWord readData;
        MemSerial readSerial;
        logic writeDone;
        MemSerial writeSerial;
    } MemResponse;

endpackage

`default_nettype wire

// File: memory.sv
/*
 * Single-port word memory with a fixed read latency and serial-tagged responses.
 * One read can be accepted per cycle, and each accepted write costs one busy cycle.
 */
`default_nettype none

module memory (
    input  logic clk,
    input  logic rst,
    input  mainTypes::MemRequest req,
    output logic busy,
    output mainTypes::MemSerial nextReadSerial,
    output mainTypes::MemSerial nextWriteSerial,
    output mainTypes::MemResponse resp
);

    mainTypes::MemWord mem [mainTypes::MEM_ENTRY_NUM];
    mainTypes::MemResponse pipe [mainTypes::MEM_READ_LATENCY];  // Stage 0 is newest
    logic readAccept;
    logic writeAccept;

    assign readAccept = req.re && !busy;
    assign writeAccept = req.we && !busy;

    always_ff @(posedge clk) begin
        if (writeAccept) begin
            mem[req.addr] <= req.wdata;
        end
    end

    // Response pipeline, the final stage drives resp
    always_ff @(posedge clk) begin
        pipe[0] <= '{
            readValid:   readAccept,
            readData:    mem[req.addr],
            readSerial:  nextReadSerial,
            writeDone:   writeAccept,
            writeSerial: nextWriteSerial
        };
        for (int i = 1; i < mainTypes::MEM_READ_LATENCY; i++) begin
            pipe[i] <= pipe[i-1];
        end
        if (rst) begin
            // Drop whatever is in flight, data stays as is
            for (int i = 0; i < mainTypes::MEM_READ_LATENCY; i++) begin
                pipe[i].readValid <= 1'b0;
                pipe[i].writeDone <= 1'b0;
            end
        end
    end

    assign resp = pipe[mainTypes::MEM_READ_LATENCY-1];

    // Busy for the cycle after a write, separate id counters per access kind
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            nextReadSerial <= '0;
            nextWriteSerial <= '0;
        end else begin
            busy <= writeAccept;
            if (readAccept) begin
                nextReadSerial <= nextReadSerial + 1'b1;  // Wraps modulo 8
            end
            if (writeAccept) begin
                nextWriteSerial <= nextWriteSerial + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: programLoader.sv
/*
 * Fills memory from a byte stream: a two-byte word count, then words lane 0 first.
 * Word k goes to address k and loaded rises once every write is acknowledged.
 */
`default_nettype none

module programLoader (
    input  logic clk,
    input  logic rst,
    input  logic [7:0] byteData,
    input  logic byteValid,
    input  logic busy,
    input  logic writeDone,
    output mainTypes::MemRequest req,
    output mainTypes::MemAddr wordCount,
    output logic loaded
);

    logic [1:0] headerBytes;        // 2 once the count is complete
    logic [1:0] lane;               // Next byte lane to fill
    mainTypes::MemWord wordBuf;
    mainTypes::MemAddr wordAddr;
    mainTypes::MemAddr ackCount;
    logic writePending;
    logic takeByte;
    logic headerDone;
    mainTypes::MemAddr fullCount;

    assign takeByte = byteValid && !loaded;
    assign headerDone = headerBytes[1];

    // Count value as it becomes when the high byte is taken
    // High byte bits above the address width are dropped
    assign fullCount = {byteData[mainTypes::ADDR_WIDTH-9:0], wordCount[7:0]};

    assign req = '{addr: wordAddr, wdata: wordBuf, re: 1'b0, we: writePending};

    // Word assembly, one lane per data byte
    always_ff @(posedge clk) begin
        if (takeByte && headerDone) begin
            wordBuf.bytes[lane] <= byteData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            headerBytes <= '0;
            lane <= '0;
            wordAddr <= '0;
            ackCount <= '0;
            writePending <= 1'b0;
            wordCount <= '0;
            loaded <= 1'b0;
        end else begin
            if (takeByte && !headerDone) begin
                headerBytes <= headerBytes + 1'b1;
                if (headerBytes == 2'd0) begin
                    wordCount[7:0] <= byteData;             // Low byte first
                end else begin
                    wordCount[mainTypes::ADDR_WIDTH-1:8] <= byteData[mainTypes::ADDR_WIDTH-9:0];
                    if (fullCount == '0) begin
                        loaded <= 1'b1;                     // Empty image
                    end
                end
            end else if (takeByte) begin
                lane <= lane + 1'b1;
                if (lane == 2'd3) begin
                    writePending <= 1'b1;                   // Word complete
                end
            end

            // Held until the memory takes it
            if (writePending && !busy) begin
                writePending <= 1'b0;
                wordAddr <= wordAddr + 1'b1;
            end

            if (writeDone && !loaded) begin
                ackCount <= ackCount + 1'b1;
                if (ackCount == wordCount - 1'b1) begin
                    loaded <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: resetController.sv
/*
 * Stretches the external active-low reset into the system reset.
 * rstStart marks the final cycle of that reset.
 */
`default_nettype none

module resetController (
    input  logic clk,
    input  logic rstN,
    output logic sysRst,
    output logic rstStart
);

    logic [$clog2(mainTypes::RESET_HOLD+1)-1:0] holdCount;

    // Restart while rstN is low, then count up and stop at RESET_HOLD
    always_ff @(posedge clk) begin
        if (!rstN) begin
            holdCount <= '0;
        end else if (holdCount != mainTypes::RESET_HOLD) begin
            holdCount <= holdCount + 1'b1;
        end
    end

    assign sysRst = (holdCount != mainTypes::RESET_HOLD);

    // Last cycle only if rstN stays high through it
    assign rstStart = rstN && (holdCount == mainTypes::RESET_HOLD - 1);

endmodule

`default_nettype wire

// File: tbClock.sv
/*
 * Free-running testbench clock, 40 time units per period, starting low.
 */
`default_nettype none

module tbClock (
    output logic clk
);

    localparam int HALF_PERIOD = 20;

    initial begin
        clk = 1'b0;
    end

    always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

// File: tbMain.sv
/*
 * Table-driven testbench for mainTop that loads LFSR images and checks the serial
 * checksum, the LED value and the reset behavior. A watchdog bounds the run time.
 */
`default_nettype none

module tbMain;

    localparam int CLK_PERIOD = 40;
    localparam int CYCLES_PER_BYTE = 40;        // Covers long runs of serialReady low
    localparam int CASE_MARGIN = 200;
    localparam logic [31:0] SEED = 32'h6052_1548;

    typedef struct packed {
        logic [9:0] count;                      // Words in the image
        logic [31:0] seedOffset;
        logic readyRandom;                      // serialReady from LFSR bits
        logic [9:0] abortWords;                 // Nonzero means rstN drops after this many words
    } CaseEntry;

    logic clk;
    logic rstN;
    logic [7:0] byteData;
    logic byteValid;
    logic serialReady;
    logic sysRstOut;
    logic serialWE;
    logic [7:0] serialWriteData;
    logic [mainTypes::LED_WIDTH-1:0] ledOut;
    logic done;

    CaseEntry cases [8];
    int numCases;
    logic [31:0] image [64];
    logic [31:0] dataLfsr;
    logic [31:0] readyLfsr;
    int errorCount;
    int checkCount;

    tbClock clkGen (.clk(clk));

    mainTop dut_i (
        .clk(clk),
        .rstN(rstN),
        .byteData(byteData),
        .byteValid(byteValid),
        .serialReady(serialReady),
        .sysRstOut(sysRstOut),
        .serialWE(serialWE),
        .serialWriteData(serialWriteData),
        .ledOut(ledOut),
        .done(done)
    );

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);  // Taps 32 30 26 25
    endfunction

    task automatic drawWord(output logic [31:0] w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            w = {w[30:0], dataLfsr[0]};
            dataLfsr = lfsrStep(dataLfsr);
        end
    endtask

    task automatic drawReadyBit(output logic bit0);
        bit0 = readyLfsr[0];
        readyLfsr = lfsrStep(readyLfsr);
    endtask

    // Sum of word k rotated left by k mod 32
    function automatic logic [31:0] checksumModel(input int count);
        logic [31:0] sum;
        logic [31:0] w;
        int s;
        sum = '0;
        for (int k = 0; k < count; k++) begin
            w = image[k];
            s = k % 32;
            sum = sum + ((w << s) | (w >> (32 - s)));
        end
        return sum;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic checkResetState(input logic rstExpected);
        checkValue("sysRstOut", sysRstOut, rstExpected);
        checkValue("serialWE", serialWE, 0);
        checkValue("done", done, 0);
        checkValue("ledOut", ledOut, 0);
    endtask

    task automatic addCase(input int count, input int offset, input logic readyRandom,
                           input int abortWords);
        cases[numCases] = {count[9:0], offset[31:0], readyRandom, abortWords[9:0]};
        numCases++;
    endtask

    task automatic applyReset();
        @(negedge clk);
        rstN = 1'b0;
        byteValid = 1'b0;
        serialReady = 1'b0;
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            if (i >= 1) checkResetState(1'b1);  // Two edges before everything is cleared
        end
        rstN = 1'b1;
        for (int i = 0; i < mainTypes::RESET_HOLD; i++) begin
            @(negedge clk);
            if (i < mainTypes::RESET_HOLD - 1) begin
                checkResetState(1'b1);
            end else begin
                checkValue("sysRstOut", sysRstOut, 0);
            end
        end
    endtask

    task automatic sendByte(input logic [7:0] b);
        @(negedge clk);
        byteData = b;
        byteValid = 1'b1;
        @(negedge clk);
        byteValid = 1'b0;
    endtask

    // Collects bytes until done. A transfer is any cycle with serialWE and serialReady high
    task automatic receiveChecksum(input logic readyRandom, output logic [31:0] got,
                                   output int gotCount);
        logic ready;
        logic waiting;
        logic doneSeen;
        logic [7:0] heldByte;
        got = '0;
        gotCount = 0;
        waiting = 1'b0;
        doneSeen = 1'b0;
        heldByte = '0;
        while (!doneSeen) begin
            @(negedge clk);
            if (waiting) begin
                checkValue("serialWE", serialWE, 1);
                checkValue("serialWriteData", serialWriteData, heldByte);
            end
            if (done) begin
                checkValue("serialWE", serialWE, 0);
                doneSeen = 1'b1;
                serialReady = 1'b0;
            end else begin
                ready = 1'b1;
                if (readyRandom) drawReadyBit(ready);
                serialReady = ready;
                if (serialWE && ready) begin
                    if (gotCount < 4) got[gotCount*8 +: 8] = serialWriteData;
                    gotCount++;
                end
                waiting = serialWE && !ready;
                heldByte = serialWriteData;
            end
        end
    endtask

    task automatic runCase(input int idx);
        CaseEntry c;
        logic [31:0] got;
        int gotCount;
        int loadWords;
        c = cases[idx];
        applyReset();
        dataLfsr = SEED ^ c.seedOffset;
        for (int k = 0; k < c.count; k++) drawWord(image[k]);
        loadWords = (c.abortWords != 0) ? c.abortWords : c.count;
        sendByte(c.count[7:0]);                 // Word count low byte first
        sendByte({6'b0, c.count[9:8]});
        for (int k = 0; k < loadWords; k++) begin
            for (int lane = 0; lane < 4; lane++) sendByte(image[k][lane*8 +: 8]);
        end
        if (c.abortWords != 0) begin
            $display("Case %0d: rstN dropped after %0d of %0d words", idx, loadWords, c.count);
        end else begin
            receiveChecksum(c.readyRandom, got, gotCount);
            checkValue("byteCount", gotCount, 4);
            checkValue("checksum", got, checksumModel(c.count));
            checkValue("ledOut", ledOut,
                       (c.count == 0) ? 0 : (c.count - 1) % (1 << mainTypes::LED_WIDTH));
            $display("Case %0d: %0d words, checksum 0x%h", idx, c.count, got);
        end
    endtask

    initial begin
        rstN = 1'b0;
        byteData = '0;
        byteValid = 1'b0;
        serialReady = 1'b0;
        errorCount = 0;
        checkCount = 0;
        numCases = 0;
        readyLfsr = SEED;
        addCase(1, 0, 1'b0, 0);
        addCase(5, 1, 1'b1, 0);
        addCase(16, 2, 1'b1, 0);
        addCase(12, 3, 1'b0, 6);                // Reset in the middle of the load
        addCase(7, 4, 1'b1, 0);
        addCase(0, 5, 1'b0, 0);
        for (int i = 0; i < numCases; i++) runCase(i);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Budget from the table covers every byte in or out plus reset and read time per case
    initial begin
        int maxCycles;
        #1;
        maxCycles = 0;
        for (int i = 0; i < numCases; i++) begin
            maxCycles += (2 + 4 * cases[i].count + 4) * CYCLES_PER_BYTE + CASE_MARGIN;
        end
        #(maxCycles * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d clock cycles", maxCycles);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire
